// File: Bender.yml
package:
  name: sd_host

sources:
  - logic/sd_host_pkg.sv
  - logic/sd_host_regs.sv
  - logic/tx_word_fifo.sv
  - logic/blk_framer.sv
  - logic/dat_lane_crc.sv
  - logic/dat_bus_drive.sv
  - logic/sd_host.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/sd_host_properties.sv
      - sim/sd_host_tb.sv

// File: logic/blk_framer.sv
// block framer FSM
// waits for a full block in the FIFO, then issues start, data,
// CRC and end beats, one per clock

`timescale 1ns/1ps

module blk_framer #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            start,
   input  sd_host_pkg::xfer_cfg_t          cfg,
   input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_level,
   output logic                            fifo_pop,
   input  logic [31:0]                     fifo_word,
   output sd_host_pkg::dat_beat_t          beat
);

   typedef enum logic [2:0] {S_IDLE, S_WAIT, S_START, S_DATA, S_CRC, S_END, S_GAP} state_e;

   state_e      state;
   logic [15:0] blk_words_q;
   logic [15:0] blocks_left;
   logic [15:0] word_cnt;           // words sent in this block
   logic [2:0]  nib_idx;            // nibble within the word, msn first
   logic [3:0]  crc_cnt;
   logic [31:0] word_q;
   logic [31:0] cur_word;
   logic        blk_ready;

   assign blk_ready = 32'(fifo_level) >= 32'(blk_words_q);
   assign fifo_pop  = state == S_DATA && nib_idx == 3'd0;
   assign cur_word  = (nib_idx == 3'd0) ? fifo_word : word_q;

   ////////////////////////////// sequencing
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= S_IDLE;
         blocks_left <= '0;
         word_cnt    <= '0;
         nib_idx     <= '0;
         crc_cnt     <= '0;
      end else begin
         case (state)
            S_IDLE: if (start) begin
               blocks_left <= cfg.blk_count;
               state       <= S_WAIT;
            end
            S_WAIT: if (blk_ready) state <= S_START;  // host stall parks here
            S_START: begin
               word_cnt <= '0;
               nib_idx  <= '0;
               state    <= S_DATA;
            end
            S_DATA: begin
               nib_idx <= nib_idx + 3'd1;
               if (nib_idx == 3'd7) begin
                  word_cnt <= word_cnt + 16'd1;
                  if (word_cnt == blk_words_q - 16'd1) begin
                     crc_cnt <= '0;
                     state   <= S_CRC;
                  end
               end
            end
            S_CRC: begin
               crc_cnt <= crc_cnt + 4'd1;
               if (crc_cnt == 4'd15) state <= S_END;
            end
            S_END: begin
               blocks_left <= blocks_left - 16'd1;
               state       <= (blocks_left == 16'd1) ? S_IDLE : S_GAP;
            end
            default: state <= S_WAIT;              // S_GAP, one idle beat
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_IDLE && start) blk_words_q <= cfg.blk_words;
      if (fifo_pop) word_q <= fifo_word;           // rest of the nibbles
   end

   ////////////////////////////// beat output
   always_comb begin
      beat.phase  = sd_host_pkg::PH_IDLE;
      beat.nibble = '1;
      beat.last   = 1'b0;
      case (state)
         S_START: begin
            beat.phase  = sd_host_pkg::PH_START;
            beat.nibble = '0;
         end
         S_DATA: begin
            beat.phase  = sd_host_pkg::PH_DATA;
            beat.nibble = cur_word[31 - 4*nib_idx -: 4];
         end
         S_CRC: beat.phase = sd_host_pkg::PH_CRC;  // lanes supply the bits
         S_END: begin
            beat.phase = sd_host_pkg::PH_END;
            beat.last  = blocks_left == 16'd1;
         end
         default: ;
      endcase
   end

endmodule

// File: logic/dat_bus_drive.sv
// DAT bus driver
// merges the lane bits onto the pins with output enable
// and flags each block end and the transfer end

`timescale 1ns/1ps

module dat_bus_drive (
   input  logic                                                    clk,
   input  logic                                                    rst_n,
   input  sd_host_pkg::lane_bit_t [sd_host_pkg::NUM_LANES-1:0]     lanes,
   output logic [sd_host_pkg::NUM_LANES-1:0]                       data_to_card,
   output logic                                                    data_to_card_oe,
   output logic                                                    block_sent,
   output logic                                                    xfer_done
);

   logic [sd_host_pkg::NUM_LANES-1:0] line_vec;
   logic                              drive;
   logic                              end_beat;

   // lane 0 carries the framing for all four
   assign drive    = lanes[0].phase != sd_host_pkg::PH_IDLE;
   assign end_beat = lanes[0].phase == sd_host_pkg::PH_END;

   always_comb begin
      for (int k = 0; k < sd_host_pkg::NUM_LANES; k++) begin
         line_vec[k] = lanes[k].line;
      end
   end

   ////////////////////////////// pin stage
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         data_to_card    <= '1;          // bus idles high
         data_to_card_oe <= 1'b0;
         block_sent      <= 1'b0;
         xfer_done       <= 1'b0;
      end else begin
         data_to_card_oe <= drive;
         data_to_card    <= drive ? line_vec : '1;
         block_sent      <= end_beat;
         xfer_done       <= end_beat && lanes[0].last;  // final end bit
      end
   end

endmodule

// File: logic/dat_lane_crc.sv
// one DAT lane
// registers the lane bit and keeps its CRC16,
// shifted out msb first during the CRC phase

`timescale 1ns/1ps

module dat_lane_crc (
   input  logic                    clk,
   input  logic                    rst_n,
   input  sd_host_pkg::dat_phase_e phase,
   input  logic                    last,
   input  logic                    data_bit,
   output sd_host_pkg::lane_bit_t  lane_out
);

   logic [sd_host_pkg::CRC_W-1:0] crc_q;
   logic [sd_host_pkg::CRC_W-1:0] crc_next;
   logic                          fb;

   // serial CRC16-CCITT step, zero seed per block
   assign fb       = crc_q[sd_host_pkg::CRC_W-1] ^ data_bit;
   assign crc_next = {crc_q[sd_host_pkg::CRC_W-2:0], 1'b0}
                     ^ (fb ? sd_host_pkg::CRC_POLY : '0);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         crc_q          <= '0;
         lane_out.phase <= sd_host_pkg::PH_IDLE;
         lane_out.line  <= 1'b1;
         lane_out.last  <= 1'b0;
      end else begin
         lane_out.phase <= phase;
         lane_out.last  <= last;
         lane_out.line  <= data_bit;
         case (phase)
            sd_host_pkg::PH_START: crc_q <= '0;
            sd_host_pkg::PH_DATA:  crc_q <= crc_next;
            sd_host_pkg::PH_CRC: begin
               lane_out.line <= crc_q[sd_host_pkg::CRC_W-1];     // remainder out
               crc_q         <= {crc_q[sd_host_pkg::CRC_W-2:0], 1'b0};
            end
            default: crc_q <= crc_q;
         endcase
      end
   end

endmodule

// File: logic/sd_host.sv
// sd_host write-data path top level
// registers, transmit FIFO, block framer, four DAT lanes
// and the bus driver

`timescale 1ns/1ps

module sd_host #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  sd_host_pkg::reg_req_t             reg_req,
   output logic [31:0]                       reg_rd_data,
   input  logic [31:0]                       host_data,
   input  logic                              host_valid,
   output logic                              host_ready,
   output logic [sd_host_pkg::NUM_LANES-1:0] data_to_card,
   output logic                              data_to_card_oe
);

   localparam int LVL_W = $clog2(FIFO_DEPTH+1);

   logic                                                start;
   sd_host_pkg::xfer_cfg_t                              cfg;
   logic                                                block_sent;
   logic                                                xfer_done;
   logic                                                fifo_pop;
   logic [31:0]                                         fifo_word;
   logic [LVL_W-1:0]                                    fifo_level;
   sd_host_pkg::dat_beat_t                              beat;
   sd_host_pkg::lane_bit_t [sd_host_pkg::NUM_LANES-1:0] lanes;

   sd_host_regs #(.FIFO_DEPTH(FIFO_DEPTH)) regs_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .reg_req    (reg_req),
      .reg_rd_data(reg_rd_data),
      .start      (start),
      .cfg        (cfg),
      .block_sent (block_sent),
      .xfer_done  (xfer_done)
   );

   tx_word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .host_data (host_data),
      .host_valid(host_valid),
      .host_ready(host_ready),
      .fifo_pop  (fifo_pop),
      .fifo_word (fifo_word),
      .fifo_level(fifo_level)
   );

   blk_framer #(.FIFO_DEPTH(FIFO_DEPTH)) framer_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .cfg       (cfg),
      .fifo_level(fifo_level),
      .fifo_pop  (fifo_pop),
      .fifo_word (fifo_word),
      .beat      (beat)
   );

   ////////////////////////////// one CRC lane per DAT line
   for (genvar k = 0; k < sd_host_pkg::NUM_LANES; k++) begin : g_lane
      dat_lane_crc lane_inst (
         .clk     (clk),
         .rst_n   (rst_n),
         .phase   (beat.phase),
         .last    (beat.last),
         .data_bit(beat.nibble[k]),   // lane k takes nibble bit k
         .lane_out(lanes[k])
      );
   end

   dat_bus_drive drive_inst (
      .clk            (clk),
      .rst_n          (rst_n),
      .lanes          (lanes),
      .data_to_card   (data_to_card),
      .data_to_card_oe(data_to_card_oe),
      .block_sent     (block_sent),
      .xfer_done      (xfer_done)
   );

endmodule

// File: logic/sd_host_pkg.sv
// sd_host package
// lane count, CRC constants, register map, beat phase enum
// and the packed structs shared by the write-data path

package sd_host_pkg;

   localparam int NUM_LANES  = 4;                // 4-bit DAT bus
   localparam int CRC_W      = 16;
   localparam logic [CRC_W-1:0] CRC_POLY = 16'h1021; // x^16+x^12+x^5+1
   localparam int REG_ADDR_W = 4;

   ////////////////////////////// register map
   localparam logic [REG_ADDR_W-1:0] ADDR_BLK_SIZE  = 4'd0;
   localparam logic [REG_ADDR_W-1:0] ADDR_BLK_COUNT = 4'd1;
   localparam logic [REG_ADDR_W-1:0] ADDR_CONTROL   = 4'd2;
   localparam logic [REG_ADDR_W-1:0] ADDR_STATUS    = 4'd3;

   // status bit positions
   localparam int STAT_BUSY     = 0;
   localparam int STAT_COMPLETE = 1;                // write one to clear
   localparam int STAT_ERROR    = 2;                // write one to clear

   // five phases, so three bits
   typedef enum logic [2:0] {
      PH_IDLE,
      PH_START,
      PH_DATA,
      PH_CRC,
      PH_END
   } dat_phase_e;

   typedef struct packed {
      dat_phase_e           phase;
      logic [NUM_LANES-1:0] nibble;
      logic                 last;                   // end beat of final block
   } dat_beat_t;

   typedef struct packed {
      dat_phase_e phase;
      logic       line;
      logic       last;
   } lane_bit_t;

   typedef struct packed {
      logic [15:0] blk_words;
      logic [15:0] blk_count;
   } xfer_cfg_t;

   typedef struct packed {
      logic [REG_ADDR_W-1:0] addr;
      logic                  wr;
      logic [31:0]           data;
   } reg_req_t;

endpackage

// File: logic/sd_host_regs.sv
// transfer registers of the write path
// block size and count, start validation,
// busy / complete / error flags and remaining-block counter

`timescale 1ns/1ps

module sd_host_regs #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  sd_host_pkg::reg_req_t  reg_req,
   output logic [31:0]            reg_rd_data,
   output logic                   start,
   output sd_host_pkg::xfer_cfg_t cfg,
   input  logic                   block_sent,
   input  logic                   xfer_done
);

   logic [15:0] blk_size_q;
   logic [15:0] blk_count_q;
   logic [15:0] remain_q;
   logic        busy_q;
   logic        complete_q;
   logic        error_q;
   logic        start_q;
   logic        try_start;
   logic        bad_cfg;
   logic        stat_wr;
   logic [31:0] status;

   assign try_start = reg_req.wr && reg_req.addr == sd_host_pkg::ADDR_CONTROL
                      && reg_req.data[0] && !busy_q;
   assign bad_cfg   = blk_size_q == '0 || blk_size_q > 16'(FIFO_DEPTH)
                      || blk_count_q == '0;
   assign stat_wr   = reg_req.wr && reg_req.addr == sd_host_pkg::ADDR_STATUS;

   always_comb begin
      status = '0;
      status[sd_host_pkg::STAT_BUSY]     = busy_q;
      status[sd_host_pkg::STAT_COMPLETE] = complete_q;
      status[sd_host_pkg::STAT_ERROR]    = error_q;
      status[31:16]                      = remain_q;
   end

   ////////////////////////////// writes and flags
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         blk_size_q  <= '0;
         blk_count_q <= '0;
         remain_q    <= '0;
         busy_q      <= 1'b0;
         complete_q  <= 1'b0;
         error_q     <= 1'b0;
         start_q     <= 1'b0;
      end else begin
         start_q <= 1'b0;
         if (reg_req.wr && reg_req.addr == sd_host_pkg::ADDR_BLK_SIZE)
            blk_size_q <= reg_req.data[15:0];
         if (reg_req.wr && reg_req.addr == sd_host_pkg::ADDR_BLK_COUNT)
            blk_count_q <= reg_req.data[15:0];

         // error set beats a same-cycle clear
         if (try_start && bad_cfg)
            error_q <= 1'b1;
         else if (stat_wr && reg_req.data[sd_host_pkg::STAT_ERROR])
            error_q <= 1'b0;

         if (xfer_done)
            complete_q <= 1'b1;
         else if (stat_wr && reg_req.data[sd_host_pkg::STAT_COMPLETE])
            complete_q <= 1'b0;

         if (try_start && !bad_cfg) begin
            start_q  <= 1'b1;           // one-cycle pulse to the framer
            busy_q   <= 1'b1;
            remain_q <= blk_count_q;
         end else begin
            if (block_sent)
               remain_q <= remain_q - 16'd1;
            if (xfer_done)
               busy_q <= 1'b0;
         end
      end
   end

   // settings frozen at start
   always_ff @(posedge clk) begin
      if (try_start && !bad_cfg) begin
         cfg.blk_words <= blk_size_q;
         cfg.blk_count <= blk_count_q;
      end
   end

   ////////////////////////////// read port, one stage
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         reg_rd_data <= '0;
      end else begin
         case (reg_req.addr)
            sd_host_pkg::ADDR_BLK_SIZE:  reg_rd_data <= {16'd0, blk_size_q};
            sd_host_pkg::ADDR_BLK_COUNT: reg_rd_data <= {16'd0, blk_count_q};
            sd_host_pkg::ADDR_STATUS:    reg_rd_data <= status;
            default:                     reg_rd_data <= '0; // control is write-only
         endcase
      end
   end

   assign start = start_q;

endmodule

// File: logic/tx_word_fifo.sv
// transmit word FIFO
// valid/ready write side, combinational pop side with fill level

`timescale 1ns/1ps

module tx_word_fifo #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic [31:0]                        host_data,
   input  logic                               host_valid,
   output logic                               host_ready,
   input  logic                               fifo_pop,
   output logic [31:0]                        fifo_word,
   output logic [$clog2(FIFO_DEPTH+1)-1:0]    fifo_level
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int LVL_W = $clog2(FIFO_DEPTH+1);

   logic [31:0]      mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [LVL_W-1:0] level_q;
   logic             push;

   assign host_ready = level_q != LVL_W'(FIFO_DEPTH); // low when full
   assign push       = host_valid && host_ready;
   assign fifo_word  = mem[rd_ptr];                    // oldest word
   assign fifo_level = level_q;

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= host_data;
   end

   // pointers wrap at FIFO_DEPTH, which need not be a power of two
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         level_q <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         if (fifo_pop)
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         case ({push, fifo_pop})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;       // both or neither
         endcase
      end
   end

endmodule

// File: sd_host.f
logic/sd_host_pkg.sv
logic/sd_host_regs.sv
logic/tx_word_fifo.sv
logic/blk_framer.sv
logic/dat_lane_crc.sv
logic/dat_bus_drive.sv
logic/sd_host.sv
sim/tb_clk_gen.sv
sim/sd_host_properties.sv
sim/sd_host_tb.sv

// File: sim/sd_host_properties.sv
// concurrent assertions on the sd_host pins and FIFO handshake
// bound into every sd_host instance

`timescale 1ns/1ps

module sd_host_properties #(
   parameter int FIFO_DEPTH = 16
) (
   input logic                              clk,
   input logic                              rst_n,
   input logic [3:0]                        data_to_card,
   input logic                              data_to_card_oe,
   input logic                              host_ready,
   input logic [$clog2(FIFO_DEPTH+1)-1:0]   fifo_level,
   input logic                              block_sent
);

   int fail_count = 0;                    // failed assertion attempts so far

   a_oe_after_reset: assert property (@(posedge clk) !rst_n |=> !data_to_card_oe)
      else begin
         $error("data_to_card_oe high right after reset");
         fail_count++;
      end

   // bus idles high whenever not driven
   a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
      !data_to_card_oe |-> data_to_card == 4'hF)
      else begin
         $error("data_to_card not all ones while oe low: %h", data_to_card);
         fail_count++;
      end

   a_full_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
      fifo_level == FIFO_DEPTH |-> !host_ready)
      else begin
         $error("host_ready high with the FIFO full");
         fail_count++;
      end

   a_sent_with_oe: assert property (@(posedge clk) disable iff (!rst_n)
      block_sent |-> data_to_card_oe)
      else begin
         $error("block_sent pulsed while oe low");
         fail_count++;
      end

endmodule

bind sd_host sd_host_properties #(.FIFO_DEPTH(FIFO_DEPTH)) props_inst (
   .clk            (clk),
   .rst_n          (rst_n),
   .data_to_card   (data_to_card),
   .data_to_card_oe(data_to_card_oe),
   .host_ready     (host_ready),
   .fifo_level     (fifo_level),
   .block_sent     (block_sent)
);

// File: sim/sd_host_tb.sv
// sd_host testbench
// random register, stream and transfer stimulus, a bus monitor,
// a reference model of block framing and lane CRC16, and the report

`timescale 1ns/1ps

module sd_host_tb;

   localparam int FIFO_DEPTH  = 16;
   localparam int BLK_TIMEOUT = 5000;       // cycles allowed per block

   logic                  clk;
   logic                  rst_n;
   sd_host_pkg::reg_req_t reg_req;
   logic [31:0]           reg_rd_data;
   logic [31:0]           host_data;
   logic                  host_valid;
   logic                  host_ready;
   logic [3:0]            data_to_card;
   logic                  data_to_card_oe;

   int          seed = 32'h8911;
   int          errors = 0;
   int          test_base = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          assert_seen = 0;            // assertion failures already counted
   int          cur_len = 0;
   logic [31:0] tx_words[$];                // words of the current transfer
   logic [3:0]  cap_nib[$];                 // every beat seen with oe high
   int          frame_len[$];
   logic [3:0]  exp_nib[$];

   tb_clk_gen #(.PERIOD(20), .RST_CYCLES(8)) clk_gen_inst (.clk(clk), .rst_n(rst_n));

   sd_host #(.FIFO_DEPTH(FIFO_DEPTH)) sd_host_inst (
      .clk            (clk),
      .rst_n          (rst_n),
      .reg_req        (reg_req),
      .reg_rd_data    (reg_rd_data),
      .host_data      (host_data),
      .host_valid     (host_valid),
      .host_ready     (host_ready),
      .data_to_card   (data_to_card),
      .data_to_card_oe(data_to_card_oe)
   );

   ////////////////////////////// bus monitor
   always @(negedge clk) begin
      if (rst_n && data_to_card_oe) begin
         cap_nib.push_back(data_to_card);
         cur_len++;
      end else if (cur_len != 0) begin
         frame_len.push_back(cur_len);       // oe fell, frame closed
         cur_len = 0;
      end
   end

   ////////////////////////////// helpers
   function automatic int rand_range(input int lo, input int hi);
      return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("Error: %s got %h expected %h", name, got, exp);
      errors++;
   endtask

   task automatic end_test(input string name);
      int fails_now;
      fails_now   = sd_host_inst.props_inst.fail_count;
      errors     += fails_now - assert_seen;    // bound assertions that fired
      assert_seen = fails_now;
      tests_run++;
      if (errors == test_base) begin
         $display("test %-18s passed", name);
      end else begin
         $display("test %-18s failed with %0d errors", name, errors - test_base);
         tests_failed++;
      end
      test_base = errors;
   endtask

   task automatic reg_write(input logic [sd_host_pkg::REG_ADDR_W-1:0] a, input logic [31:0] d);
      @(posedge clk);
      reg_req.addr <= a;
      reg_req.wr   <= 1'b1;
      reg_req.data <= d;
      @(posedge clk);
      reg_req.wr   <= 1'b0;
   endtask

   task automatic reg_read(input logic [sd_host_pkg::REG_ADDR_W-1:0] a, output logic [31:0] d);
      @(posedge clk);
      reg_req.addr <= a;
      reg_req.wr   <= 1'b0;
      @(posedge clk);                        // read stage loads here
      @(negedge clk);
      d = reg_rd_data;
   endtask

   // one bit into x^16+x^12+x^5+1, msb first
   function automatic logic [15:0] crc_shift(input logic [15:0] c, input logic b);
      logic        fb;
      logic [15:0] n;
      fb    = c[15] ^ b;
      n     = c << 1;
      n[0]  = fb;
      n[5]  = n[5] ^ fb;
      n[12] = n[12] ^ fb;
      return n;
   endfunction

   ////////////////////////////// reference frame of one block
   function automatic void build_frame(input int first, input int w);
      logic [15:0] crc [sd_host_pkg::NUM_LANES];
      logic [3:0]  nib;
      exp_nib.delete();
      for (int k = 0; k < sd_host_pkg::NUM_LANES; k++) crc[k] = '0;
      exp_nib.push_back(4'h0);               // start bit on all lanes
      for (int i = 0; i < w; i++) begin
         for (int n = 7; n >= 0; n--) begin
            nib = tx_words[first + i][4*n +: 4];
            exp_nib.push_back(nib);
            for (int k = 0; k < sd_host_pkg::NUM_LANES; k++) crc[k] = crc_shift(crc[k], nib[k]);
         end
      end
      for (int i = 15; i >= 0; i--) begin
         for (int k = 0; k < sd_host_pkg::NUM_LANES; k++) nib[k] = crc[k][i];
         exp_nib.push_back(nib);
      end
      exp_nib.push_back(4'hF);               // end bit
   endfunction

   task automatic check_frames(input int w, input int cnt);
      int pos;
      int bad;
      pos = 0;
      if (frame_len.size() != cnt) begin
         $display("wrong number of blocks on the bus: %0d, expected %0d", frame_len.size(), cnt);
         errors++;
      end
      for (int b = 0; b < cnt && b < frame_len.size(); b++) begin
         build_frame(b * w, w);
         if (frame_len[b] != 8 * w + 18)
            report_mismatch("data_to_card_oe frame length", frame_len[b], 8 * w + 18);
         bad = 0;
         for (int i = 0; i < exp_nib.size() && pos + i < cap_nib.size() && bad == 0; i++) begin
            if (cap_nib[pos + i] !== exp_nib[i]) begin
               $display("Error: data_to_card block %0d beat %0d got %h expected %h",
                        b, i, cap_nib[pos + i], exp_nib[i]);
               errors++;
               bad = 1;
            end
         end
         pos += frame_len[b];
      end
   endtask

   ////////////////////////////// host stream and transfer control
   task automatic send_words(input int gap_pct);
      int   idx;
      int   guard;
      logic rdy;
      idx   = 0;
      guard = 0;
      while (idx < tx_words.size() && guard < 8 * BLK_TIMEOUT) begin
         @(negedge clk);
         rdy = host_ready;
         @(posedge clk);
         guard++;
         if (host_valid && rdy) idx++;
         if (!host_valid || rdy) begin       // a waiting word stays put
            if (idx < tx_words.size() && rand_range(0, 99) >= gap_pct) begin
               host_valid <= 1'b1;
               host_data  <= tx_words[idx];
            end else begin
               host_valid <= 1'b0;
            end
         end
      end
      host_valid <= 1'b0;
      if (idx < tx_words.size()) begin
         $display("timeout: host stream stuck after %0d of %0d words", idx, tx_words.size());
         errors++;
      end
   endtask

   task automatic watch_blocks(input int cnt);
      int          guard;
      logic [31:0] st;
      st = '0;
      for (int b = 1; b <= cnt; b++) begin
         guard = 0;
         while (frame_len.size() < b && guard < BLK_TIMEOUT) begin
            @(posedge clk);
            guard++;
         end
         if (frame_len.size() < b) begin
            $display("timeout: block %0d of %0d never reached the DAT bus", b, cnt);
            errors++;
            return;
         end
         reg_read(sd_host_pkg::ADDR_STATUS, st);
         if (st[31:16] !== 16'(cnt - b))
            report_mismatch("reg_rd_data blocks remaining", st[31:16], cnt - b);
      end
      if (st[0] !== 1'b0) report_mismatch("reg_rd_data status busy", st[0], 0);
      if (st[1] !== 1'b1) report_mismatch("reg_rd_data status complete", st[1], 1);
   endtask

   task automatic run_transfer(input int w, input int cnt, input int gap_pct, input int delay);
      logic [31:0] st;
      tx_words.delete();
      cap_nib.delete();
      frame_len.delete();
      for (int i = 0; i < w * cnt; i++) tx_words.push_back($random(seed));
      reg_write(sd_host_pkg::ADDR_BLK_SIZE, w);
      reg_write(sd_host_pkg::ADDR_BLK_COUNT, cnt);
      fork
         send_words(gap_pct);
         begin
            repeat (delay) @(posedge clk);   // lets the FIFO fill up first
            reg_write(sd_host_pkg::ADDR_CONTROL, 32'h1);
            watch_blocks(cnt);
         end
      join
      check_frames(w, cnt);
      reg_write(sd_host_pkg::ADDR_STATUS, 32'h2);
      reg_read(sd_host_pkg::ADDR_STATUS, st);
      if (st[1] !== 1'b0) report_mismatch("reg_rd_data complete after clear", st[1], 0);
   endtask

   task automatic bad_start(input logic [15:0] w, input logic [15:0] cnt);
      logic [31:0] st;
      reg_write(sd_host_pkg::ADDR_BLK_SIZE, w);
      reg_write(sd_host_pkg::ADDR_BLK_COUNT, cnt);
      reg_write(sd_host_pkg::ADDR_CONTROL, 32'h1);
      reg_read(sd_host_pkg::ADDR_STATUS, st);
      if (st[2] !== 1'b1) report_mismatch("reg_rd_data status error", st[2], 1);
      if (st[0] !== 1'b0) report_mismatch("reg_rd_data status busy", st[0], 0);
      for (int i = 0; i < 200; i++) begin
         @(negedge clk);
         if (data_to_card_oe) begin
            $display("data_to_card_oe rose after a rejected start (size %0d, count %0d)", w, cnt);
            errors++;
            break;
         end
      end
      reg_write(sd_host_pkg::ADDR_STATUS, 32'h4);
      reg_read(sd_host_pkg::ADDR_STATUS, st);
      if (st[2] !== 1'b0) report_mismatch("reg_rd_data error after clear", st[2], 0);
   endtask

   ////////////////////////////// test sequence
   initial begin
      int          guard;
      logic [31:0] rd;
      logic [15:0] size_v;
      logic [15:0] count_v;
      reg_req    = '0;
      host_data  = '0;
      host_valid = 1'b0;
      guard      = 0;
      while (rst_n !== 1'b1 && guard < 100) begin
         @(posedge clk);
         guard++;
      end
      if (rst_n !== 1'b1) begin
         $display("timeout: reset was never released");
         errors++;
      end

      reg_read(sd_host_pkg::ADDR_STATUS, rd);
      if (rd !== 32'h0) report_mismatch("reg_rd_data status after reset", rd, 0);
      for (int i = 0; i < 4; i++) begin
         size_v  = $random(seed);
         count_v = $random(seed);
         reg_write(sd_host_pkg::ADDR_BLK_SIZE, size_v);
         reg_write(sd_host_pkg::ADDR_BLK_COUNT, count_v);
         reg_read(sd_host_pkg::ADDR_BLK_SIZE, rd);
         if (rd !== {16'd0, size_v}) report_mismatch("reg_rd_data block size", rd, size_v);
         reg_read(sd_host_pkg::ADDR_BLK_COUNT, rd);
         if (rd !== {16'd0, count_v}) report_mismatch("reg_rd_data block count", rd, count_v);
      end
      end_test("register readback");

      run_transfer(rand_range(1, FIFO_DEPTH), 1, 0, 0);
      end_test("single block");

      run_transfer(rand_range(1, FIFO_DEPTH), rand_range(2, 5), 20, 0);
      end_test("multiple blocks");

      run_transfer(rand_range(1, FIFO_DEPTH), 4, 60, 0);
      run_transfer(rand_range(8, FIFO_DEPTH), 3, 0, 100);   // FIFO runs full
      end_test("host back-pressure");

      bad_start(16'd0, 16'd2);
      bad_start(16'(FIFO_DEPTH + 1), 16'd2);
      bad_start(16'd4, 16'd0);
      end_test("bad settings");

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: sim/tb_clk_gen.sv
// testbench clock and reset
// free-running clk, rst_n held low for the first cycles

`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD     = 20,
   parameter int RST_CYCLES = 8
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;                      // released on a rising edge
   end

endmodule
